//--- all.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/decoder.sv
hdl/imm_extender.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/rv_core.sv
dv/rv_core_properties.sv
dv/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f all.f

sim_out="$(./obj_dir/Vtb_rv_core)" || true
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int          PROG_LEN   = 200;
    localparam int          MAX_CYCLES = 2 * PROG_LEN;  // one instruction per cycle, doubled
    localparam logic [31:0] END_ADDR   = 32'(PROG_LEN * 4);
    localparam logic [31:0] SEED       = 32'h8e75_1464;

    logic        clk_i;
    logic        arst_n_i;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_data_i;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_we_o;
    logic [31:0] dmem_rdata_i;
    logic        illegal_o;

    logic [31:0] imem [256];
    string       tag [256];  // test name of each instruction
    logic [31:0] dmem [64];
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [64];
    logic [31:0] m_pc;
    logic [31:0] lcg_state;
    int          gen_idx;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    rv_core i_rv_core (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .illegal_o    (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // memories read asynchronously
    assign imem_data_i  = imem[imem_addr_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        logic [31:0] a;
        a = idx << 2;
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i[5:0]] <= fill_word(32'(i));
            end
        end else if (dmem_we_o) begin
            dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the program did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_below(input logic [31:0] n);
        return (next_rand() >> 8) % n;  // low lcg bits are weak
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(32));
    endfunction

    function automatic logic [4:0] rand_rd();
        return 5'(rand_below(31) + 32'd1);  // never x0
    endfunction

    function automatic logic [11:0] slot_offset();
        logic [31:0] r;
        r = rand_below(64);
        return {4'b0, r[5:0], 2'b00};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};  // base is x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word, input string name);
        imem[gen_idx[7:0]] = word;
        tag[gen_idx[7:0]]  = name;
        gen_idx++;
    endtask

    task automatic emit_alu(output logic [4:0] rd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] r;
        rd = rand_rd();
        r  = rand_below(8);
        f3 = r[2:0];
        r  = next_rand();
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[20]) ? 7'h20 : 7'h00;  // sub, sra
        if (r[24]) begin
            emit(enc_r(f7, rand_reg(), rand_reg(), f3, rd), "alu");
        end else begin
            imm = 12'(next_rand());
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {f7, imm[4:0]};  // shifts keep funct7 in the upper bits
            end
            emit(enc_i(imm, rand_reg(), f3, rd, 7'h13), "alu imm");
        end
    endtask

    // jump over k-1 filler instructions and store the link register at the target
    task automatic emit_jump(input logic reg_jump);
        logic [31:0] k;
        logic [31:0] tgt;
        logic [4:0]  rd;
        logic [4:0]  skip_rd;
        rd  = rand_rd();
        k   = 32'd2 + rand_below(3);
        tgt = 32'(gen_idx) * 4 + k * 4;
        if (reg_jump) begin
            emit(enc_i(12'(tgt + rand_below(2)), 5'd0, 3'b000, rd, 7'h67), "jalr");
        end else begin
            emit(enc_j(21'(k * 4), rd), "jal");
        end
        for (int i = 1; i < int'(k); i++) begin
            emit_alu(skip_rd);
        end
        emit(enc_sw(slot_offset(), rd), reg_jump ? "jalr link store" : "jal link store");
    endtask

    task automatic gen_program();
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0]  rd;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = 32'h0000_0013;  // addi x0, x0, 0
            tag[i[7:0]]  = "nop";
        end
        gen_idx = 0;
        // fetched while reset is held, so the data memory must stay untouched then
        emit(enc_sw(slot_offset(), rand_reg()), "reset store");
        emit(32'h0000_0073, "ecall");
        while (gen_idx < PROG_LEN) begin
            kind = rand_below(8);
            if (PROG_LEN - gen_idx < 6) begin
                emit_alu(rd);
            end else begin
                case (kind)
                    0, 1: begin
                        emit_alu(rd);
                        emit(enc_sw(slot_offset(), rd), "alu store");
                    end
                    2: begin
                        rd = rand_rd();
                        emit(enc_i(slot_offset(), 5'd0, 3'b010, rd, 7'h03), "load");
                        emit(enc_sw(slot_offset(), rd), "load store");
                    end
                    3: begin
                        r = rand_below(6);
                        if (r >= 32'd2) begin
                            r = r + 32'd2;  // skip the two unused funct3 codes
                        end
                        rd = rand_reg();
                        emit(enc_b(13'((32'd1 + rand_below(5)) * 4), rd,
                                   next_rand() % 4 == 0 ? rd : rand_reg(), r[2:0]), "branch");
                    end
                    4: emit_jump(1'b0);
                    5: emit_jump(1'b1);
                    6: begin
                        rd = rand_rd();
                        r  = next_rand();
                        emit({r[31:12], rd, r[7] ? 7'h37 : 7'h17}, r[7] ? "lui" : "auipc");
                        emit(enc_sw(slot_offset(), rd), r[7] ? "lui store" : "auipc store");
                    end
                    default: emit(32'h0000_0073, "ecall");
                endcase
            end
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [31:0]        sra;
        sa  = a;
        sra = sa >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    // one instruction of the reference model, compared against the DUT mid-cycle
    task automatic check_and_step();
        logic [31:0] ins;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] imm_i;
        logic [31:0] wval;
        logic [31:0] addr;
        logic [31:0] npc;
        logic        wr;
        logic        st;
        logic        ill;
        string       name;
        ins   = imem[m_pc[9:2]];
        name  = tag[m_pc[9:2]];
        x1    = m_regs[ins[19:15]];
        x2    = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        wr    = 1'b0;
        st    = 1'b0;
        ill   = 1'b0;
        wval  = '0;
        addr  = '0;
        npc   = m_pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                wr   = 1'b1;
                wval = alu_model(ins[14:12], ins[30], x1, x2);
            end
            7'h13: begin
                wr   = 1'b1;
                wval = alu_model(ins[14:12], ins[14:12] == 3'd5 && ins[30], x1, imm_i);
            end
            7'h03: begin
                wr   = 1'b1;
                addr = x1 + imm_i;
                wval = m_mem[addr[7:2]];
            end
            7'h23: begin
                st   = 1'b1;
                addr = x1 + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            7'h63: begin
                if (branch_taken(ins[14:12], x1, x2)) begin
                    npc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h37: begin
                wr   = 1'b1;
                wval = {ins[31:12], 12'b0};
            end
            7'h17: begin
                wr   = 1'b1;
                wval = m_pc + {ins[31:12], 12'b0};
            end
            7'h6f: begin
                wr   = 1'b1;
                wval = m_pc + 32'd4;
                npc  = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                wr   = 1'b1;
                wval = m_pc + 32'd4;
                npc  = (x1 + imm_i) & ~32'd1;
            end
            default: ill = 1'b1;  // ecall, fence and unknown opcodes
        endcase

        checks++;
        if (imem_addr_o !== m_pc) report_mismatch({name, " pc"}, m_pc, imem_addr_o);
        if (illegal_o !== ill) report_mismatch({name, " illegal"}, 32'(ill), 32'(illegal_o));
        if (dmem_we_o !== st) report_mismatch({name, " write enable"}, 32'(st), 32'(dmem_we_o));
        if (st) begin
            if (dmem_addr_o !== addr) report_mismatch({name, " address"}, addr, dmem_addr_o);
            if (dmem_wdata_o !== x2) report_mismatch({name, " data"}, x2, dmem_wdata_o);
            m_mem[addr[7:2]] = x2;
        end
        if (wr && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = wval;
        end
        m_pc = npc;
    endtask

    initial begin
        arst_n_i <= 1'b0;
        lcg_state = SEED;
        gen_program();
        for (int i = 0; i < 64; i++) begin
            m_mem[i[5:0]] = fill_word(32'(i));
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i[4:0]] = '0;
        end
        m_pc = '0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        while (m_pc < END_ADDR) begin
            @(negedge clk_i);  // outputs settled since the last edge
            check_and_step();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic [31:0] imem_addr_i,
    input logic        dmem_we_i,
    input logic        illegal_i
);

    // fetch address stays on word boundaries
    fetch_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) imem_addr_i[1:0] == 2'b00
    ) else $error("fetch address %h is not word aligned", imem_addr_i);

    illegal_no_store: assert property (
        @(posedge clk_i) illegal_i |-> !dmem_we_i  // illegal instructions act as nops
    ) else $error("data memory written by an illegal instruction");

    reset_no_store: assert property (
        @(posedge clk_i) !arst_n_i |-> !dmem_we_i
    ) else $error("data memory written while in reset");

endmodule

bind rv_core rv_core_properties i_rv_core_properties (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .imem_addr_i (imem_addr_o),
    .dmem_we_i   (dmem_we_o),
    .illegal_i   (illegal_o)
);

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic        clk_i,
    input  logic        arst_n_i,

    // instruction memory
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_data_i,

    // data memory, word access only
    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,
    output logic        dmem_we_o,
    input  logic [31:0] dmem_rdata_i,

    output logic        illegal_o
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic        br_taken;

    funct3_t     funct3;
    alu7_t       alu7;
    src1_t       src1;
    src2_t       src2;
    srcr_t       srcr;
    next_pc_t    pc_ctrl;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] imm32;
    logic        reg_write;
    logic        data_read;
    logic        data_write;
    logic        illegal;

    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic [31:0] mem_data;
    logic [31:0] wb_data;

    decoder i_decoder (
        .instr_i      (imem_data_i),
        .funct3_o     (funct3),
        .alu7_o       (alu7),
        .src1_o       (src1),
        .src2_o       (src2),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .imm12_o      (imm12),
        .imm20_o      (imm20),
        .srcr_o       (srcr),
        .rd_o         (rd),
        .reg_write_o  (reg_write),
        .data_read_o  (data_read),
        .data_write_o (data_write),
        .pc_control_o (pc_ctrl),
        .illegal_o    (illegal)
    );

    imm_extender i_imm_extender (
        .imm12_i (imm12),
        .imm20_i (imm20),
        .src2_i  (src2),
        .imm32_o (imm32)
    );

    reg_file i_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (rd),
        .we_i     (reg_write),
        .wd_i     (wb_data),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    always_comb begin
        case (src1)
            RS1:     alu_a = rd1;
            PC:      alu_a = pc;
            default: alu_a = '0;
        endcase
    end

    assign alu_b = (src2 == RS2) ? rd2 : imm32;

    alu i_alu (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .funct3_i (funct3),
        .alu7_i   (alu7),
        .result_o (alu_res)
    );

    // branch comparator works on the raw register values
    always_comb begin
        case (funct3.br)
            BEQ:     br_taken = (rd1 == rd2);
            BNE:     br_taken = (rd1 != rd2);
            BLT:     br_taken = ($signed(rd1) < $signed(rd2));
            BGE:     br_taken = ($signed(rd1) >= $signed(rd2));
            BLTU:    br_taken = (rd1 < rd2);
            BGEU:    br_taken = (rd1 >= rd2);
            default: br_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + imm32;

    always_comb begin
        pc_next = pc_plus4;
        if (!illegal) begin
            case (pc_ctrl)
                BRANCH:   pc_next = br_taken ? br_target : pc_plus4;
                JUMP:     pc_next = alu_res;
                JUMP_REG: pc_next = {alu_res[31:1], 1'b0};
                default:  pc_next = pc_plus4;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next; // one instruction retires per edge
        end
    end

    assign mem_data = data_read ? dmem_rdata_i : '0;

    always_comb begin
        case (srcr)
            MEM_DATA: wb_data = mem_data;
            LINK:     wb_data = pc_plus4;
            default:  wb_data = alu_res;
        endcase
    end

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_res;
    assign dmem_wdata_o = rd2;
    assign dmem_we_o    = data_write & arst_n_i; // no stores while held in reset
    assign illegal_o    = illegal;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        we_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    import isa_pkg::*;

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wd_i; // x0 never written, so it reads back zero
        end
    end

    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]      a_i,
    input  logic [31:0]      b_i,
    input  isa_pkg::funct3_t funct3_i,
    input  isa_pkg::alu7_t   alu7_i,
    output logic [31:0]      result_o
);

    import isa_pkg::*;

    logic [4:0]  shamt;
    logic        alt;
    logic [31:0] sra_res;

    assign shamt = b_i[4:0]; // rv32 shifts use the low 5 bits
    assign alt   = alu7_i[5];

    // kept apart so the shift stays signed
    assign sra_res = $signed(a_i) >>> shamt;

    always_comb begin
        case (funct3_i.alu)
            ADD: begin
                result_o = alt ? (a_i - b_i) : (a_i + b_i);
            end
            SLL: begin
                result_o = a_i << shamt;
            end
            SLT: begin
                result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            end
            SLTU: begin
                result_o = {31'b0, a_i < b_i};
            end
            XOR: begin
                result_o = a_i ^ b_i;
            end
            R_SHIFT: begin
                result_o = alt ? sra_res : (a_i >> shamt);
            end
            OR: begin
                result_o = a_i | b_i;
            end
            AND: begin
                result_o = a_i & b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/imm_extender.sv
`timescale 1ns/1ps
`default_nettype none

module imm_extender (
    input  logic [11:0]     imm12_i,
    input  logic [19:0]     imm20_i,
    input  ctrl_pkg::src2_t src2_i,  // immediate kind
    output logic [31:0]     imm32_o
);

    import ctrl_pkg::*;

    always_comb begin
        case (src2_i)
            IS_IMM12: begin
                imm32_o = {{20{imm12_i[11]}}, imm12_i};
            end
            B_IMM12: begin
                // branch offsets are in halfwords
                imm32_o = {{19{imm12_i[11]}}, imm12_i, 1'b0};
            end
            U_IMM: begin
                imm32_o = {imm20_i, 12'b0};
            end
            J_IMM: begin
                imm32_o = {{11{imm20_i[19]}}, imm20_i, 1'b0};
            end
            default: begin
                imm32_o = '0; // register operand, no immediate
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [31:0]        instr_i,

    // operation
    output isa_pkg::funct3_t   funct3_o,
    output isa_pkg::alu7_t     alu7_o,

    // operands
    output ctrl_pkg::src1_t    src1_o,
    output ctrl_pkg::src2_t    src2_o, // also picks the immediate kind
    output logic [4:0]         rs1_o,
    output logic [4:0]         rs2_o,
    output logic [11:0]        imm12_o,
    output logic [19:0]        imm20_o,

    // result
    output ctrl_pkg::srcr_t    srcr_o,
    output logic [4:0]         rd_o,
    output logic               reg_write_o,
    output logic               data_read_o,
    output logic               data_write_o,
    output ctrl_pkg::next_pc_t pc_control_o,
    output logic               illegal_o
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    opc_t        opc;
    funct3_t     funct3;
    alu7_t       funct7;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [11:0] b_imm;
    logic [19:0] u_imm;
    logic [19:0] j_imm;

    assign opc    = opc_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = alu7_t'(instr_i[31:25]);

    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];

    // bits put back in order, extension and shift happen in imm_extender
    assign i_imm = instr_i[31:20];
    assign s_imm = {instr_i[31:25], instr_i[11:7]};
    assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};
    assign u_imm = instr_i[31:12];
    assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21]};

    assign imm20_o = (opc == J) ? j_imm : u_imm;

    always_comb begin
        // address arithmetic by default
        funct3_o.alu = ADD;
        alu7_o       = I_STD;
        src1_o       = RS1;
        src2_o       = RS2;
        imm12_o      = i_imm;
        srcr_o       = RESULT;
        reg_write_o  = 1'b0;
        data_read_o  = 1'b0;
        data_write_o = 1'b0;
        pc_control_o = NEXT;
        illegal_o    = 1'b0;

        case (opc)
            R: begin
                funct3_o    = funct3;
                alu7_o      = funct7;
                reg_write_o = 1'b1;
            end
            I_ALU: begin
                funct3_o = funct3;
                // only shifts carry funct7 in the immediate
                if (funct3.alu == SLL || funct3.alu == R_SHIFT) begin
                    alu7_o = funct7;
                end
                src2_o      = IS_IMM12;
                reg_write_o = 1'b1;
            end
            I_LD: begin
                src2_o      = IS_IMM12;
                srcr_o      = MEM_DATA;
                reg_write_o = 1'b1;
                data_read_o = 1'b1;
            end
            S: begin
                src2_o       = IS_IMM12;
                imm12_o      = s_imm;
                data_write_o = 1'b1;
            end
            B: begin
                funct3_o     = funct3; // read as a branch condition by the core
                src1_o       = PC;
                src2_o       = B_IMM12;
                imm12_o      = b_imm;
                pc_control_o = BRANCH;
            end
            U_AUIPC: begin
                src1_o      = PC;
                src2_o      = U_IMM;
                reg_write_o = 1'b1;
            end
            U_LUI: begin
                src1_o      = ZERO; // 0 + imm
                src2_o      = U_IMM;
                reg_write_o = 1'b1;
            end
            J: begin
                src1_o       = PC;
                src2_o       = J_IMM;
                srcr_o       = LINK;
                reg_write_o  = 1'b1;
                pc_control_o = JUMP;
            end
            I_JALR: begin
                src2_o       = IS_IMM12;
                srcr_o       = LINK;
                reg_write_o  = 1'b1;
                pc_control_o = JUMP_REG;
            end
            I_ENV, FENCE: begin
                illegal_o = 1'b1; // no system support, treated as a nop
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // first alu operand
    typedef enum logic [1:0] {
        RS1  = 2'd0,
        PC   = 2'd1,
        ZERO = 2'd2  // lui
    } src1_t;

    // second alu operand, doubles as the immediate kind
    typedef enum logic [2:0] {
        RS2      = 3'd0,
        IS_IMM12 = 3'd1, // i and s formats share one extension
        B_IMM12  = 3'd2,
        U_IMM    = 3'd3,
        J_IMM    = 3'd4
    } src2_t;

    // register write-back source
    typedef enum logic [1:0] {
        RESULT   = 2'd0,
        MEM_DATA = 2'd1,
        LINK     = 2'd2  // pc + 4
    } srcr_t;

    typedef enum logic [1:0] {
        NEXT     = 2'd0,
        BRANCH   = 2'd1,
        JUMP     = 2'd2,
        JUMP_REG = 2'd3  // jalr, bit 0 cleared
    } next_pc_t;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int          NUM_REGS = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        R       = 7'b0110011,
        I_ALU   = 7'b0010011,
        I_LD    = 7'b0000011,
        S       = 7'b0100011,
        B       = 7'b1100011,
        U_AUIPC = 7'b0010111,
        U_LUI   = 7'b0110111,
        J       = 7'b1101111,
        I_JALR  = 7'b1100111,
        I_ENV   = 7'b1110011, // ecall / ebreak
        FENCE   = 7'b0001111
    } opc_t;

    // funct3 seen by the alu
    typedef enum logic [2:0] {
        ADD     = 3'b000, // also sub
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        R_SHIFT = 3'b101, // srl or sra
        OR      = 3'b110,
        AND     = 3'b111
    } alu_op_t;

    // funct3 seen by the branch comparator
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_op_t;

    typedef union packed {
        alu_op_t alu;
        br_op_t  br;
    } funct3_t;

    typedef enum logic [6:0] {
        I_STD = 7'b0000000,
        ALT   = 7'b0100000  // sub, sra
    } alu7_t;

endpackage

`default_nettype wire
